// ==== compile.f ====
common/gpio_lite_cfg_pkg.sv
common/gpio_lite_regs_pkg.sv
gpio_lite/gpio_lite_pin_sync.sv
gpio_lite/gpio_lite_apb_slave.sv
gpio_lite/gpio_lite_subunit.sv
source/gpio_lite_top.sv
sim/gpio_lite_tb.sv

// ==== Makefile ====
# Verilator build and run of the gpio lite testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module gpio_lite_tb \
		-f compile.f -Mdir obj_dir -o gpio_lite_sim

run: compile
	@out="$$(./obj_dir/gpio_lite_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir

// ==== sim/gpio_lite_tb.sv ====
// gpio lite testbench
// table driven test of the APB GPIO block: register readback, pin drive,
// input sync path, rising edge interrupts and the clear on read status
`timescale 1ns/1ps
`default_nettype none

module gpio_lite_tb
  import gpio_lite_cfg_pkg::*;
  import gpio_lite_regs_pkg::*;
();

  localparam int gpio_width   = 16;
  localparam int reset_cycles = 10;

  typedef enum logic [2:0] {op_wr, op_rd, op_rd_model, op_pins, op_rand_pins, op_chk} op_t;

  typedef struct packed {
    op_t       op;
    reg_addr_t addr;
    reg_data_t data;     // write data
    reg_data_t pins;     // pin_in, set-pins rows only
    reg_data_t tri_st;   // test_tri_state, applied on every row
    reg_data_t exp_rd;   // prdata
    reg_data_t exp_out;  // pin_out
    reg_data_t exp_oen;  // pin_oe_n
    reg_data_t exp_int;  // interrupt, irq is its OR
  } row_t;

  logic                      pclk11;
  logic                      n_reset11;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_addr_width-1:0] paddr;
  logic [apb_data_width-1:0] pwdata;
  logic [apb_data_width-1:0] prdata;
  logic                      pready;
  logic [gpio_width-1:0]     pin_in;
  logic [gpio_width-1:0]     test_tri_state;
  logic [gpio_width-1:0]     pin_out;
  logic [gpio_width-1:0]     pin_oe_n;
  logic [gpio_width-1:0]     interrupt;
  logic                      irq;

  row_t      rows[$];
  int        checks;
  int        errors;
  int        row_idx;
  reg_data_t dir_model;   // direction as last written
  reg_data_t last_pins;   // pin_in before the current change
  reg_data_t pend_model;  // status bits that should be pending

  always #4 pclk11 = ~pclk11;  // 8 ns period

  gpio_lite_top #(
    .gpio_width (gpio_width)
  ) dut_i (.*);

  task automatic check_value(input string what, input reg_data_t got, input reg_data_t exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED at %0t: row %0d %s got %h expected %h",
               $time, row_idx, what, got, exp);
      errors++;
    end
  endtask

  function automatic void add_row(op_t op, reg_addr_t addr, reg_data_t data, reg_data_t pins,
                                  reg_data_t tri_st, reg_data_t exp_rd, reg_data_t exp_out,
                                  reg_data_t exp_oen, reg_data_t exp_int);
    row_t row;
    row = '{op, addr, data, pins, tri_st, exp_rd, exp_out, exp_oen, exp_int};
    rows.push_back(row);
  endfunction

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  // op, addr, data, pins, tri, prdata, pin_out, pin_oe_n, interrupt
  function automatic void build_table();
    add_row(op_rd, gpr_direction_mode, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_output_enable, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_output_value, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_input_value, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_int_status, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_chk, 6'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'hffff, 16'h0);  // all tri-stated
    // upper byte inputs, lower byte driven
    add_row(op_wr, gpr_direction_mode, 16'hff00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_wr, gpr_output_enable, 16'h0fff, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_wr, gpr_output_value, 16'ha5c3, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_direction_mode, 16'h0, 16'h0, 16'h0, 16'hff00, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_output_enable, 16'h0, 16'h0, 16'h0, 16'h0fff, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_output_value, 16'h0, 16'h0, 16'h0, 16'ha5c3, 16'h0, 16'h0, 16'h0);
    add_row(op_chk, 6'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'ha5c3, 16'hff00, 16'h0);
    add_row(op_chk, 6'h00, 16'h0, 16'h0, 16'h000f, 16'h0, 16'ha5c3, 16'hff0f, 16'h0);
    add_row(op_chk, 6'h00, 16'h0, 16'h0, 16'hf0f0, 16'h0, 16'ha5c3, 16'hfff0, 16'h0);
    // input path, rises only count on the upper byte
    add_row(op_pins, 6'h00, 16'h0, 16'h1234, 16'h0, 16'h0, 16'h0, 16'h0, 16'h1200);
    add_row(op_rd, gpr_input_value, 16'h0, 16'h0, 16'h0, 16'h1234, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, 6'h3c, 16'h0, 16'h0, 16'h0, 16'h1234, 16'h0, 16'h0, 16'h0);  // hole
    add_row(op_rd, gpr_int_status, 16'h0, 16'h0, 16'h0, 16'h1200, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_int_status, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_chk, 6'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'ha5c3, 16'hff00, 16'h0);
    // falls, then rises on output pins only
    add_row(op_pins, 6'h00, 16'h0, 16'h0034, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_pins, 6'h00, 16'h0, 16'h00ff, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_pins, 6'h00, 16'h0, 16'h80ff, 16'h0, 16'h0, 16'h0, 16'h0, 16'h8000);
    add_row(op_rd, gpr_int_status, 16'h0, 16'h0, 16'h0, 16'h8000, 16'h0, 16'h0, 16'h0);
    // random pins, expected from the pin record
    add_row(op_rand_pins, 6'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rand_pins, 6'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd_model, gpr_int_status, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rand_pins, 6'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd_model, gpr_int_status, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_rd, gpr_int_status, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
    add_row(op_chk, 6'h00, 16'h0, 16'h0, 16'h0, 16'h0, 16'ha5c3, 16'hff00, 16'h0);
  endfunction

  // ----------------------------------------
  // APB master
  // ----------------------------------------
  // called on a falling edge, returns on a falling edge
  task automatic apb_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata);
    int waits;
    waits   = 0;
    psel    = 1'b1;  // setup cycle
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge pclk11);
    penable = 1'b1;  // access cycle
    @(posedge pclk11);
    while (!pready)
    begin
      waits++;
      @(posedge pclk11);
    end
    rdata = prdata;  // value just before the edge that ends the access
    check_value("apb wait states", 16'(waits), 16'h0);
    @(negedge pclk11);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  initial
  begin
    reg_data_t got;
    reg_data_t exp_val;
    reg_data_t pins;
    row_t      r;

    void'($urandom(32'h64146f32));  // single seed for the run
    build_table();
    pclk11         = 1'b0;
    n_reset11      = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    pin_in         = '0;
    test_tri_state = '0;
    checks         = 0;
    errors         = 0;
    row_idx        = -1;
    dir_model      = gprv_direction_mode;
    last_pins      = '0;
    pend_model     = '0;
    repeat (reset_cycles) @(posedge pclk11);
    @(negedge pclk11);
    n_reset11 = 1'b1;
    check_value("pready after reset", 16'(pready), 16'h0);
    check_value("prdata after reset", prdata, 16'h0);
    check_value("irq after reset", 16'(irq), 16'h0);

    for (row_idx = 0; row_idx < rows.size(); row_idx++)
    begin
      r              = rows[row_idx];
      test_tri_state = r.tri_st;
      case (r.op)
        op_wr:
        begin
          apb_access(1'b1, r.addr, r.data, got);
          if (r.addr == gpr_direction_mode)
            dir_model = r.data;
        end
        op_rd, op_rd_model:
        begin
          apb_access(1'b0, r.addr, 16'h0, got);
          exp_val = (r.op == op_rd_model) ? pend_model : r.exp_rd;
          check_value($sformatf("prdata at 0x%h", r.addr), got, exp_val);
          if (r.addr == gpr_int_status)
            pend_model = '0;  // read clears
        end
        op_pins, op_rand_pins:
        begin
          pins       = (r.op == op_rand_pins) ? 16'($urandom) : r.pins;
          pend_model = pend_model | (dir_model & pins & ~last_pins);  // input-mode rises
          last_pins  = pins;
          pin_in     = pins;
          repeat (4) @(posedge pclk11);  // past the 3 edge sync latency
          @(negedge pclk11);
          exp_val = (r.op == op_rand_pins) ? pend_model : r.exp_int;
          check_value("interrupt", interrupt, exp_val);
          check_value("irq", 16'(irq), 16'(|exp_val));
        end
        op_chk:
        begin
          @(posedge pclk11);
          check_value("pin_out", pin_out, r.exp_out);
          check_value("pin_oe_n", pin_oe_n, r.exp_oen);
          check_value("interrupt", interrupt, r.exp_int);
          check_value("irq", 16'(irq), 16'(|r.exp_int));
          @(negedge pclk11);
        end
        default:
        begin
          $display("row %0d has an unknown operation", row_idx);
          errors++;
        end
      endcase
    end

    @(negedge pclk11);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // bounded by the table length
  initial
  begin : watchdog
    int limit;
    @(negedge pclk11);  // table built at time zero
    limit = rows.size() * 12 + 100 + reset_cycles;
    repeat (limit) @(posedge pclk11);
    $display("the run did not finish within %0d clock cycles and was stopped", limit);
    $display("Test failed");
    $finish;
  end

endmodule : gpio_lite_tb

`default_nettype wire

// ==== source/gpio_lite_top.sv ====
// gpio lite top level
// APB peripheral with a configurable number of general purpose pins;
// joins the bus slave to the GPIO register file
`timescale 1ns/1ps
`default_nettype none

module gpio_lite_top
  import gpio_lite_cfg_pkg::*;
#(
  parameter int gpio_width = gpio_width_default
)
(
  input  logic                      pclk11,
  input  logic                      n_reset11,
  // APB
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [apb_data_width-1:0] pwdata,
  output logic [apb_data_width-1:0] prdata,
  output logic                      pready,
  // pins
  input  logic [gpio_width-1:0]     pin_in,
  input  logic [gpio_width-1:0]     test_tri_state,  // dft override
  output logic [gpio_width-1:0]     pin_out,
  output logic [gpio_width-1:0]     pin_oe_n,
  output logic [gpio_width-1:0]     interrupt,
  output logic                      irq
);

  // ----------------------------------------
  // slave to register file
  // ----------------------------------------
  logic                      read;
  logic                      write;
  logic [apb_addr_width-1:0] addr;
  logic [apb_data_width-1:0] wdata;
  logic [apb_data_width-1:0] rdata;

  gpio_lite_apb_slave apb_slave_i (
    .pclk11    (pclk11),
    .n_reset11 (n_reset11),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata)
  );

  gpio_lite_subunit #(
    .gpio_width       (gpio_width)
  ) subunit_i (
    .pclk11           (pclk11),
    .n_reset11        (n_reset11),
    .read             (read),
    .write            (write),
    .addr             (addr),
    .wdata            (wdata),
    .pin_in           (pin_in),
    .tri_state_enable (test_tri_state),
    .rdata            (rdata),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n),
    .interrupt        (interrupt),
    .irq              (irq)
  );

endmodule : gpio_lite_top

`default_nettype wire

// ==== gpio_lite/gpio_lite_subunit.sv ====
// gpio lite subunit
// register file of the GPIO block: direction, output enable and output
// value registers, the clear on read interrupt status, the registered
// read mux and the pin drive logic
`timescale 1ns/1ps
`default_nettype none

module gpio_lite_subunit
  import gpio_lite_cfg_pkg::*;
  import gpio_lite_regs_pkg::*;
#(
  parameter int gpio_width = gpio_width_default
)
(
  input  logic                      pclk11,
  input  logic                      n_reset11,
  // strobes from the bus slave
  input  logic                      read,
  input  logic                      write,
  input  logic [apb_addr_width-1:0] addr,
  input  logic [apb_data_width-1:0] wdata,
  // pins
  input  logic [gpio_width-1:0]     pin_in,
  input  logic [gpio_width-1:0]     tri_state_enable,  // dft, forces Z
  output logic [apb_data_width-1:0] rdata,
  output logic [gpio_width-1:0]     pin_out,
  output logic [gpio_width-1:0]     pin_oe_n,          // active low
  output logic [gpio_width-1:0]     interrupt,         // per pin
  output logic                      irq                // any pin
);

  typedef logic [apb_data_width-1:0] bus_t;

  logic [gpio_width-1:0] direction_mode;     // 1 = input
  logic [gpio_width-1:0] output_enable;
  logic [gpio_width-1:0] output_value;
  logic [gpio_width-1:0] input_value;        // from the synchronizer
  logic [gpio_width-1:0] int_status;
  logic [gpio_width-1:0] rise_event;
  logic [gpio_width-1:0] interrupt_trigger;  // 1 sets a status bit
  logic [gpio_width-1:0] status_clear;       // 1 clears a status bit

  logic ad_direction_mode;
  logic ad_output_enable;
  logic ad_output_value;
  logic ad_int_status;

  // ----------------------------------------
  // input path
  // ----------------------------------------
  gpio_lite_pin_sync #(
    .gpio_width  (gpio_width)
  ) pin_sync_i (
    .pclk11      (pclk11),
    .n_reset11   (n_reset11),
    .pin_in      (pin_in),
    .sync_value  (),            // edges come out ready made
    .input_value (input_value),
    .rise_event  (rise_event)
  );

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  assign ad_direction_mode = (addr == gpr_direction_mode);
  assign ad_output_enable  = (addr == gpr_output_enable);
  assign ad_output_value   = (addr == gpr_output_value);
  assign ad_int_status     = (addr == gpr_int_status);

  // read-write registers, updated at the end of the access cycle
  always_ff @(posedge pclk11 or negedge n_reset11)
  begin
    if (!n_reset11)
    begin
      direction_mode <= gprv_direction_mode[gpio_width-1:0];
      output_enable  <= gprv_output_enable[gpio_width-1:0];
      output_value   <= gprv_output_value[gpio_width-1:0];
    end
    else if (write)
    begin
      if (ad_direction_mode)
        direction_mode <= wdata[gpio_width-1:0];
      if (ad_output_enable)
        output_enable <= wdata[gpio_width-1:0];
      if (ad_output_value)
        output_value <= wdata[gpio_width-1:0];  // upper bits dropped
    end
  end

  // ----------------------------------------
  // interrupt status
  // ----------------------------------------
  // only pins in input mode can raise an interrupt
  assign interrupt_trigger = direction_mode & rise_event;
  assign status_clear      = {gpio_width{read & ad_int_status}};  // read strobe is 1 cycle

  always_ff @(posedge pclk11 or negedge n_reset11)
  begin
    if (!n_reset11)
      int_status <= gprv_int_status[gpio_width-1:0];
    else
      int_status <= (int_status & ~status_clear) | interrupt_trigger;  // set wins
  end

  assign interrupt = int_status;
  assign irq       = |int_status;

  // ----------------------------------------
  // read mux
  // ----------------------------------------
  always_ff @(posedge pclk11 or negedge n_reset11)
  begin
    if (!n_reset11)
      rdata <= '0;
    else if (read)
    begin
      case (addr)
        gpr_direction_mode: rdata <= bus_t'(direction_mode);
        gpr_output_enable:  rdata <= bus_t'(output_enable);
        gpr_output_value:   rdata <= bus_t'(output_value);
        gpr_int_status:     rdata <= bus_t'(int_status);  // old value, clears now
        default:            rdata <= bus_t'(input_value);  // input reg and holes
      endcase
    end
    else
      rdata <= '0;  // back to zero between reads
  end

  // pin drive
  assign pin_out  = output_value;
  assign pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

endmodule : gpio_lite_subunit

`default_nettype wire

// ==== gpio_lite/gpio_lite_apb_slave.sv ====
// gpio lite APB slave
// turns the APB setup / access phases into single cycle read and write
// strobes for the register file, never inserts a wait state
`timescale 1ns/1ps
`default_nettype none

module gpio_lite_apb_slave
  import gpio_lite_cfg_pkg::*;
(
  input  logic                      pclk11,
  input  logic                      n_reset11,   // async, active low
  // APB side
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [apb_data_width-1:0] pwdata,
  output logic [apb_data_width-1:0] prdata,
  output logic                      pready,
  // register file side
  output logic                      read,        // setup cycle of a read
  output logic                      write,       // access cycle of a write
  output logic [apb_addr_width-1:0] addr,
  output logic [apb_data_width-1:0] wdata,
  input  logic [apb_data_width-1:0] rdata        // registered by subunit
);

  logic setup_phase;   // psel without penable
  logic access_phase;  // psel with penable
  logic read_pending;  // a read strobe went out last cycle

  // ----------------------------------------
  // phase decode
  // ----------------------------------------
  assign setup_phase  = psel & ~penable;
  assign access_phase = psel & penable;

  // read strobe early so rdata is ready by the access cycle
  assign read  = setup_phase & ~pwrite;
  assign write = access_phase & pwrite;  // regs update at end of access

  assign addr  = paddr;   // offsets used as is
  assign wdata = pwdata;

  // ----------------------------------------
  // read return
  // ----------------------------------------
  always_ff @(posedge pclk11 or negedge n_reset11)
  begin
    if (!n_reset11)
      read_pending <= 1'b0;
    else
      read_pending <= read;  // one cycle, matches the access cycle
  end

  assign pready = access_phase;  // zero wait states

  // bus held at zero outside the access cycle of a read
  assign prdata = (read_pending & access_phase) ? rdata : '0;

endmodule : gpio_lite_apb_slave

`default_nettype wire

// ==== gpio_lite/gpio_lite_pin_sync.sv ====
// gpio lite pin synchronizer
// two flop metastability chain on the pins, followed by the input value
// register; a pin that was low and is now high gives a rise event
`timescale 1ns/1ps
`default_nettype none

module gpio_lite_pin_sync
#(
  parameter int gpio_width = 16
)
(
  input  logic                  pclk11,
  input  logic                  n_reset11,
  input  logic [gpio_width-1:0] pin_in,       // asynchronous pins
  output logic [gpio_width-1:0] sync_value,   // after two stages
  output logic [gpio_width-1:0] input_value,  // one stage later
  output logic [gpio_width-1:0] rise_event    // low to high seen
);

  logic [gpio_width-1:0] stage_one;  // first flop, may go metastable

  // ----------------------------------------
  // sample chain
  // ----------------------------------------
  always_ff @(posedge pclk11 or negedge n_reset11)
  begin
    if (!n_reset11)
    begin
      stage_one   <= '0;
      sync_value  <= '0;
      input_value <= '0;
    end
    else
    begin
      stage_one   <= pin_in;
      sync_value  <= stage_one;   // safe to use from here on
      input_value <= sync_value;  // previous sample, also the ro register
    end
  end

  // new value high, old value low
  assign rise_event = sync_value & ~input_value;

endmodule : gpio_lite_pin_sync

`default_nettype wire

// ==== common/gpio_lite_regs_pkg.sv ====
// gpio lite register map
// byte offsets of the programmer visible registers and their values
// after reset, full data bus width
`default_nettype none

package gpio_lite_regs_pkg;

  import gpio_lite_cfg_pkg::*;

  typedef logic [apb_addr_width-1:0] reg_addr_t;
  typedef logic [apb_data_width-1:0] reg_data_t;

  // ----------------------------------------
  // offsets
  // ----------------------------------------
  localparam reg_addr_t gpr_direction_mode = 6'h04;  // 1 = input, 0 = output
  localparam reg_addr_t gpr_output_enable  = 6'h08;  // per pin drive enable
  localparam reg_addr_t gpr_output_value   = 6'h0C;  // value put on the pins
  localparam reg_addr_t gpr_input_value    = 6'h10;  // synced pins, ro
  localparam reg_addr_t gpr_int_status     = 6'h20;  // rise events, ro, clear on read

  // ----------------------------------------
  // reset values
  // ----------------------------------------
  // everything comes up as a disabled output with no pending status
  localparam reg_data_t gprv_direction_mode = '0;  // all outputs
  localparam reg_data_t gprv_output_enable  = '0;  // all tri-stated
  localparam reg_data_t gprv_output_value   = '0;  // drive low once enabled
  localparam reg_data_t gprv_input_value    = '0;  // nothing sampled yet
  localparam reg_data_t gprv_int_status     = '0;  // status clear

endpackage : gpio_lite_regs_pkg

`default_nettype wire

// ==== common/gpio_lite_cfg_pkg.sv ====
// gpio lite configuration
// bus widths of the APB port and the default pin count of the block
`default_nettype none

package gpio_lite_cfg_pkg;

  // ----------------------------------------
  // APB bus
  // ----------------------------------------
  localparam int apb_addr_width = 6;       // byte address, 64 byte window
  localparam int apb_data_width = 16;      // prdata / pwdata width

  // ----------------------------------------
  // pins
  // ----------------------------------------
  localparam int gpio_width_default = 16;  // must not exceed apb_data_width

endpackage : gpio_lite_cfg_pkg

`default_nettype wire
